//--- common/uart_console_settings.svh
`ifndef UART_CONSOLE_SETTINGS_SVH
`define UART_CONSOLE_SETTINGS_SVH

// ********************
// baud rate
// ********************

// divisor loaded at reset
`define UART_RESET_DIVISOR 16'd27

// ********************
// host register map
// ********************

`define REG_DIVISOR 2'd0
`define REG_DATA    2'd1
`define REG_STATUS  2'd2
`define REG_CONTROL 2'd3

`endif

//--- common/uart_console_pkg.sv
package uart_console_pkg;

	// ********************
	// data widths
	// ********************

	// one byte on the serial line
	typedef logic [7:0] uart_byte_t;

	// clock cycles per 1/16 bit
	typedef logic [15:0] divisor_t;

	// host register select
	typedef logic [1:0] reg_addr_t;

	// ********************
	// state machines
	// ********************

	// position inside an outgoing frame
	typedef enum logic [1:0] {
		tx_st_idle  = 2'd0,
		tx_st_start = 2'd1,
		tx_st_data  = 2'd2,
		tx_st_stop  = 2'd3
	} tx_state_t;

	// position inside an incoming frame
	typedef enum logic [1:0] {
		rx_st_idle  = 2'd0,
		rx_st_start = 2'd1,
		rx_st_data  = 2'd2,
		rx_st_stop  = 2'd3
	} rx_state_t;

	// transmitter ownership
	typedef enum logic {
		arb_st_idle = 1'b0,
		arb_st_busy = 1'b1
	} arb_state_t;

endpackage

//--- uart/uart_transceiver.sv
`timescale 1ns/1ps

module uart_transceiver (
	input  logic                         sys_clk,
	input  logic                         sys_rst,
	input  logic                         uart_rx,
	output logic                         uart_tx,
	input  uart_console_pkg::divisor_t   divisor,
	output uart_console_pkg::uart_byte_t rx_data,
	output logic                         rx_done,
	input  uart_console_pkg::uart_byte_t tx_data,
	input  logic                         tx_wr,
	output logic                         tx_done
);

	// ********************
	// enable16 tick
	// ********************

	// down counter, one tick per 1/16 bit
	uart_console_pkg::divisor_t enable16_counter;
	logic                       enable16;

	assign enable16 = (enable16_counter == 16'd0);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			enable16_counter <= divisor - 16'd1;
		end else if (enable16) begin
			// reload on zero
			enable16_counter <= divisor - 16'd1;
		end else begin
			enable16_counter <= enable16_counter - 16'd1;
		end
	end

	// ********************
	// rx synchronizer
	// ********************

	logic uart_rx1;
	logic uart_rx2;

	// two flops, idle line is high
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			uart_rx1 <= 1'b1;
			uart_rx2 <= 1'b1;
		end else begin
			uart_rx1 <= uart_rx;
			uart_rx2 <= uart_rx1;
		end
	end

	// ********************
	// receiver
	// ********************

	uart_console_pkg::rx_state_t  rx_state;
	logic [3:0]                   rx_count16;
	logic [2:0]                   rx_bitcount;
	uart_console_pkg::uart_byte_t rx_reg;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			rx_state    <= uart_console_pkg::rx_st_idle;
			rx_done     <= 1'b0;
			rx_count16  <= 4'd0;
			rx_bitcount <= 3'd0;
		end else begin
			// single cycle pulse
			rx_done <= 1'b0;
			if (enable16) begin
				rx_count16 <= rx_count16 + 4'd1;
				case (rx_state)
					uart_console_pkg::rx_st_idle: begin
						rx_count16 <= 4'd0;
						// falling edge seen on the line
						if (!uart_rx2) begin
							rx_state <= uart_console_pkg::rx_st_start;
						end
					end
					uart_console_pkg::rx_st_start: begin
						// half a bit later, still low means a real start bit
						if (rx_count16 == 4'd7) begin
							rx_count16 <= 4'd0;
							if (!uart_rx2) begin
								rx_bitcount <= 3'd0;
								rx_state    <= uart_console_pkg::rx_st_data;
							end else begin
								// glitch, back to waiting
								rx_state <= uart_console_pkg::rx_st_idle;
							end
						end
					end
					uart_console_pkg::rx_st_data: begin
						// mid-bit sample, lsb first
						if (rx_count16 == 4'd15) begin
							rx_reg      <= {uart_rx2, rx_reg[7:1]};
							rx_bitcount <= rx_bitcount + 3'd1;
							if (rx_bitcount == 3'd7) begin
								rx_state <= uart_console_pkg::rx_st_stop;
							end
						end
					end
					uart_console_pkg::rx_st_stop: begin
						// middle of the stop bit
						if (rx_count16 == 4'd15) begin
							// bad stop bit drops the byte
							if (uart_rx2) begin
								rx_data <= rx_reg;
								rx_done <= 1'b1;
							end
							rx_state <= uart_console_pkg::rx_st_idle;
						end
					end
					default: rx_state <= uart_console_pkg::rx_st_idle;
				endcase
			end
		end
	end

	// ********************
	// transmitter
	// ********************

	uart_console_pkg::tx_state_t  tx_state;
	logic [3:0]                   tx_count16;
	logic [2:0]                   tx_bitcount;
	uart_console_pkg::uart_byte_t tx_reg;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			tx_state    <= uart_console_pkg::tx_st_idle;
			tx_done     <= 1'b0;
			uart_tx     <= 1'b1;
			tx_count16  <= 4'd0;
			tx_bitcount <= 3'd0;
		end else begin
			tx_done <= 1'b0;
			if (tx_wr) begin
				// start bit goes out on the next cycle
				tx_reg     <= tx_data;
				uart_tx    <= 1'b0;
				tx_count16 <= 4'd0;
				tx_state   <= uart_console_pkg::tx_st_start;
			end else if (enable16 && (tx_state != uart_console_pkg::tx_st_idle)) begin
				tx_count16 <= tx_count16 + 4'd1;
				// end of the current bit
				if (tx_count16 == 4'd15) begin
					case (tx_state)
						uart_console_pkg::tx_st_start: begin
							uart_tx     <= tx_reg[0];
							tx_reg      <= {1'b0, tx_reg[7:1]};
							tx_bitcount <= 3'd0;
							tx_state    <= uart_console_pkg::tx_st_data;
						end
						uart_console_pkg::tx_st_data: begin
							if (tx_bitcount == 3'd7) begin
								// stop bit
								uart_tx  <= 1'b1;
								tx_state <= uart_console_pkg::tx_st_stop;
							end else begin
								uart_tx     <= tx_reg[0];
								tx_reg      <= {1'b0, tx_reg[7:1]};
								tx_bitcount <= tx_bitcount + 3'd1;
							end
						end
						uart_console_pkg::tx_st_stop: begin
							tx_done  <= 1'b1;
							tx_state <= uart_console_pkg::tx_st_idle;
						end
						default: tx_state <= uart_console_pkg::tx_st_idle;
					endcase
				end
			end
		end
	end

	// arbiter must wait for tx_done before the next write
	a_tx_wr_when_idle: assert property (@(posedge sys_clk) disable iff (sys_rst)
		tx_wr |-> (tx_state == uart_console_pkg::tx_st_idle));

	// line rests high between frames
	a_tx_line_idle_high: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(tx_state == uart_console_pkg::tx_st_idle) |-> uart_tx);

endmodule

//--- design/tx_arbiter.sv
`timescale 1ns/1ps

module tx_arbiter (
	input  logic                         sys_clk,
	input  logic                         sys_rst,
	input  logic                         host_req,
	input  uart_console_pkg::uart_byte_t host_byte,
	input  logic                         echo_req,
	input  uart_console_pkg::uart_byte_t echo_byte,
	input  logic                         tx_done,
	output logic                         host_grant,
	output logic                         echo_grant,
	output logic                         tx_wr,
	output uart_console_pkg::uart_byte_t tx_data
);

	uart_console_pkg::arb_state_t arb_state;
	// set when the host got the last grant
	logic last_host;
	logic pick_host;
	logic pick_echo;

	// ********************
	// round robin pick
	// ********************

	// host wins unless echo waits too and host went last
	assign pick_host = host_req && (!echo_req || !last_host);
	assign pick_echo = echo_req && !pick_host;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			arb_state  <= uart_console_pkg::arb_st_idle;
			last_host  <= 1'b0;
			host_grant <= 1'b0;
			echo_grant <= 1'b0;
			tx_wr      <= 1'b0;
		end else begin
			host_grant <= 1'b0;
			echo_grant <= 1'b0;
			tx_wr      <= 1'b0;
			case (arb_state)
				uart_console_pkg::arb_st_idle: begin
					if (pick_host || pick_echo) begin
						// grant and write leave together
						host_grant <= pick_host;
						echo_grant <= pick_echo;
						tx_wr      <= 1'b1;
						tx_data    <= pick_host ? host_byte : echo_byte;
						last_host  <= pick_host;
						arb_state  <= uart_console_pkg::arb_st_busy;
					end
				end
				uart_console_pkg::arb_st_busy: begin
					// frame finished on the line
					if (tx_done) begin
						arb_state <= uart_console_pkg::arb_st_idle;
					end
				end
				default: arb_state <= uart_console_pkg::arb_st_idle;
			endcase
		end
	end

	a_one_grant: assert property (@(posedge sys_clk) disable iff (sys_rst)
		!(host_grant && echo_grant));

	// grants only come out of idle
	a_grant_from_idle: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(host_grant || echo_grant) |-> $past(arb_state == uart_console_pkg::arb_st_idle));

endmodule

//--- design/echo_responder.sv
`timescale 1ns/1ps

module echo_responder (
	input  logic                         sys_clk,
	input  logic                         sys_rst,
	input  logic                         echo_en,
	input  logic                         rx_done,
	input  uart_console_pkg::uart_byte_t rx_data,
	input  logic                         echo_grant,
	output logic                         echo_req,
	output uart_console_pkg::uart_byte_t echo_byte
);

	uart_console_pkg::uart_byte_t swapped;
	logic                         is_upper;
	logic                         is_lower;
	logic                         accept;

	// ********************
	// case swap
	// ********************

	// 'A' to 'Z'
	assign is_upper = (rx_data >= 8'h41) && (rx_data <= 8'h5a);
	// 'a' to 'z'
	assign is_lower = (rx_data >= 8'h61) && (rx_data <= 8'h7a);
	// bit 5 tells the cases apart in ascii
	assign swapped = (is_upper || is_lower) ? (rx_data ^ 8'h20) : rx_data;

	// ********************
	// holding register
	// ********************

	// free, or being released this cycle
	assign accept = echo_en && rx_done && (!echo_req || echo_grant);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			echo_req <= 1'b0;
		end else if (accept) begin
			echo_req <= 1'b1;
		end else if (echo_grant) begin
			echo_req <= 1'b0;
		end
	end

	// byte waits here until granted
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			echo_byte <= swapped;
		end
	end

endmodule

//--- design/host_port.sv
`timescale 1ns/1ps
`include "uart_console_settings.svh"

module host_port (
	input  logic                         sys_clk,
	input  logic                         sys_rst,
	input  logic                         host_wr,
	input  logic                         host_rd,
	input  uart_console_pkg::reg_addr_t  host_addr,
	input  logic [15:0]                  host_wdata,
	input  uart_console_pkg::uart_byte_t rx_data,
	input  logic                         rx_done,
	input  logic                         host_grant,
	input  logic                         echo_req,
	output logic [15:0]                  host_rdata,
	output uart_console_pkg::divisor_t   divisor,
	output logic                         echo_en,
	output logic                         host_req,
	output uart_console_pkg::uart_byte_t host_byte
);

	// received byte and its flags
	uart_console_pkg::uart_byte_t rx_byte;
	logic                         rx_valid;
	logic                         overrun;

	// ********************
	// address decode
	// ********************

	logic wr_divisor;
	logic wr_data;
	logic wr_control;
	logic rd_data;
	logic rd_status;

	assign wr_divisor = host_wr && (host_addr == `REG_DIVISOR);
	assign wr_data    = host_wr && (host_addr == `REG_DATA);
	assign wr_control = host_wr && (host_addr == `REG_CONTROL);
	assign rd_data    = host_rd && (host_addr == `REG_DATA);
	assign rd_status  = host_rd && (host_addr == `REG_STATUS);

	// ********************
	// write side
	// ********************

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			divisor  <= `UART_RESET_DIVISOR;
			echo_en  <= 1'b0;
			host_req <= 1'b0;
		end else begin
			if (wr_divisor) begin
				divisor <= host_wdata;
			end
			if (wr_control) begin
				echo_en <= host_wdata[0];
			end
			// a new write re-arms even in the grant cycle
			if (wr_data) begin
				host_req <= 1'b1;
			end else if (host_grant) begin
				host_req <= 1'b0;
			end
		end
	end

	// transmit holding byte, a later write overwrites it
	always_ff @(posedge sys_clk) begin
		if (wr_data) begin
			host_byte <= host_wdata[7:0];
		end
	end

	// ********************
	// receive side
	// ********************

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			rx_valid <= 1'b0;
			overrun  <= 1'b0;
		end else begin
			if (rx_done) begin
				rx_valid <= 1'b1;
			end else if (rd_data) begin
				rx_valid <= 1'b0;
			end
			// previous byte still unread
			if (rx_done && rx_valid && !rd_data) begin
				overrun <= 1'b1;
			end else if (rd_status) begin
				overrun <= 1'b0;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rx_done) begin
			rx_byte <= rx_data;
		end
	end

	// ********************
	// read data
	// ********************

	// valid the cycle after host_rd
	always_ff @(posedge sys_clk) begin
		if (host_rd) begin
			case (host_addr)
				`REG_DIVISOR: host_rdata <= divisor;
				`REG_DATA:    host_rdata <= {8'd0, rx_byte};
				// pending, valid, overrun, echo pending
				`REG_STATUS:  host_rdata <= {12'd0, echo_req, overrun, rx_valid, host_req};
				default:      host_rdata <= {15'd0, echo_en};
			endcase
		end
	end

endmodule

//--- design/uart_console.sv
`timescale 1ns/1ps

module uart_console (
	input  logic                        sys_clk,
	input  logic                        sys_rst,
	input  logic                        uart_rx,
	output logic                        uart_tx,
	input  logic                        host_wr,
	input  logic                        host_rd,
	input  uart_console_pkg::reg_addr_t host_addr,
	input  logic [15:0]                 host_wdata,
	output logic [15:0]                 host_rdata
);

	// ********************
	// internal nets
	// ********************

	// baud and mode
	uart_console_pkg::divisor_t   divisor;
	logic                         echo_en;

	// requesters toward the arbiter
	logic                         host_req;
	uart_console_pkg::uart_byte_t host_byte;
	logic                         host_grant;
	logic                         echo_req;
	uart_console_pkg::uart_byte_t echo_byte;
	logic                         echo_grant;

	// transceiver strobes
	logic                         tx_wr;
	uart_console_pkg::uart_byte_t tx_data;
	logic                         tx_done;
	uart_console_pkg::uart_byte_t rx_data;
	logic                         rx_done;

	host_port u_host_port (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.host_wr    (host_wr),
		.host_rd    (host_rd),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.rx_data    (rx_data),
		.rx_done    (rx_done),
		.host_grant (host_grant),
		.echo_req   (echo_req),
		.host_rdata (host_rdata),
		.divisor    (divisor),
		.echo_en    (echo_en),
		.host_req   (host_req),
		.host_byte  (host_byte)
	);

	echo_responder u_echo_responder (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.echo_en    (echo_en),
		.rx_done    (rx_done),
		.rx_data    (rx_data),
		.echo_grant (echo_grant),
		.echo_req   (echo_req),
		.echo_byte  (echo_byte)
	);

	// host and echo share one transmitter
	tx_arbiter u_tx_arbiter (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.host_req   (host_req),
		.host_byte  (host_byte),
		.echo_req   (echo_req),
		.echo_byte  (echo_byte),
		.tx_done    (tx_done),
		.host_grant (host_grant),
		.echo_grant (echo_grant),
		.tx_wr      (tx_wr),
		.tx_data    (tx_data)
	);

	uart_transceiver u_uart_transceiver (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.uart_rx (uart_rx),
		.uart_tx (uart_tx),
		.divisor (divisor),
		.rx_data (rx_data),
		.rx_done (rx_done),
		.tx_data (tx_data),
		.tx_wr   (tx_wr),
		.tx_done (tx_done)
	);

endmodule

//--- tb/tb_uart_console.sv
`timescale 1ns/1ps
`include "uart_console_settings.svh"

module tb_uart_console;

	// ********************
	// dut hookup
	// ********************

	logic                        sys_clk;
	logic                        sys_rst;
	logic                        uart_rx;
	logic                        uart_tx;
	logic                        host_wr;
	logic                        host_rd;
	uart_console_pkg::reg_addr_t host_addr;
	logic [15:0]                 host_wdata;
	logic [15:0]                 host_rdata;

	// serial timing follows the last divisor written
	integer bit_cycles;

	// bytes decoded from uart_tx in arrival order
	uart_console_pkg::uart_byte_t tx_bytes[$];

	integer value_errors;
	integer other_errors;
	integer cycle_count;
	integer cycle_limit;

	uart_console dut (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.uart_rx    (uart_rx),
		.uart_tx    (uart_tx),
		.host_wr    (host_wr),
		.host_rd    (host_rd),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata)
	);

	// 40 ns period
	always #20 sys_clk = ~sys_clk;

	// ********************
	// helpers
	// ********************

	task automatic compare_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		assert (actual === expected) else begin
			$display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic report_counts();
		$display("error count: %0d value, %0d other", value_errors, other_errors);
	endtask

	// one write strobe from falling edge to falling edge
	task automatic reg_write(input uart_console_pkg::reg_addr_t addr, input logic [15:0] data);
		@(negedge sys_clk);
		host_wr    = 1'b1;
		host_addr  = addr;
		host_wdata = data;
		@(negedge sys_clk);
		host_wr = 1'b0;
		// line driver and monitor follow the new baud
		if (addr == `REG_DIVISOR) begin
			bit_cycles = 16 * data;
		end
	endtask

	// rdata is registered and stable by the next falling edge
	task automatic reg_read(input uart_console_pkg::reg_addr_t addr, input logic [15:0] expected);
		@(negedge sys_clk);
		host_rd   = 1'b1;
		host_addr = addr;
		@(negedge sys_clk);
		host_rd = 1'b0;
		compare_value("host_rdata", expected, host_rdata);
	endtask

	// 8N1 frame on uart_rx with the lsb first
	task automatic send_serial(input uart_console_pkg::uart_byte_t value);
		logic [9:0] frame;
		integer     i;
		frame = {1'b1, value, 1'b0};
		@(negedge sys_clk);
		for (i = 0; i < 10; i++) begin
			uart_rx = frame[i];
			repeat (bit_cycles) @(negedge sys_clk);
		end
	endtask

	// waits until the monitor has queued a byte
	task automatic expect_tx_byte(input uart_console_pkg::uart_byte_t expected);
		uart_console_pkg::uart_byte_t actual;
		while (tx_bytes.size() == 0) @(negedge sys_clk);
		actual = tx_bytes.pop_front();
		compare_value("uart_tx byte", {8'd0, expected}, {8'd0, actual});
	endtask

	task automatic skip_line(input integer fd);
		integer ch;
		ch = $fgetc(fd);
		while ((ch != 10) && (ch != -1)) ch = $fgetc(fd);
	endtask

	task automatic report_bad_line(input logic [7:0] cmd);
		$display("test data line with command %c is malformed or unknown", cmd);
		other_errors++;
	endtask

	// ********************
	// command interpreter
	// ********************

	task automatic execute_command(input integer fd, input logic [7:0] cmd);
		integer      n;
		integer      count;
		logic [15:0] arg_a;
		logic [15:0] arg_b;
		case (cmd)
			"#": skip_line(fd);
			"L": begin
				n = $fscanf(fd, "%d", count);
				if (n != 1) report_bad_line(cmd);
				else cycle_limit = count;
			end
			"W": begin
				n = $fscanf(fd, "%h %h", arg_a, arg_b);
				if (n != 2) report_bad_line(cmd);
				else reg_write(arg_a[1:0], arg_b);
			end
			"R": begin
				n = $fscanf(fd, "%h %h", arg_a, arg_b);
				if (n != 2) report_bad_line(cmd);
				else reg_read(arg_a[1:0], arg_b);
			end
			"S": begin
				n = $fscanf(fd, "%h", arg_a);
				if (n != 1) report_bad_line(cmd);
				else send_serial(arg_a[7:0]);
			end
			"T": begin
				n = $fscanf(fd, "%h", arg_a);
				if (n != 1) report_bad_line(cmd);
				else expect_tx_byte(arg_a[7:0]);
			end
			"D": begin
				n = $fscanf(fd, "%d", count);
				if (n != 1) report_bad_line(cmd);
				else repeat (count) @(negedge sys_clk);
			end
			default: report_bad_line(cmd);
		endcase
	endtask

	// ********************
	// uart_tx monitor
	// ********************

	always begin : tx_monitor
		uart_console_pkg::uart_byte_t shift;
		integer                       i;
		@(negedge sys_clk);
		if (uart_tx === 1'b0) begin
			// middle of the start bit
			repeat (bit_cycles / 2) @(negedge sys_clk);
			assert (uart_tx === 1'b0) else begin
				$display("start bit on uart_tx ended early at %0t", $time);
				other_errors++;
			end
			for (i = 0; i < 8; i++) begin
				repeat (bit_cycles) @(negedge sys_clk);
				shift[i] = uart_tx;
			end
			// middle of the stop bit
			repeat (bit_cycles) @(negedge sys_clk);
			assert (uart_tx === 1'b1) else begin
				$display("stop bit missing on uart_tx at %0t", $time);
				other_errors++;
			end
			tx_bytes.push_back(shift);
		end
	end

	// run limit from the data file
	always @(posedge sys_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			other_errors++;
			$display("run stopped after %0d cycles, a command never completed", cycle_limit);
			report_counts();
			$display("Finished with errors");
			$finish;
		end
	end

	// ********************
	// main sequence
	// ********************

	initial begin : stimulus
		integer      fd;
		integer      n;
		logic [7:0]  cmd;
		sys_clk      = 1'b0;
		sys_rst      = 1'b1;
		uart_rx      = 1'b1;
		host_wr      = 1'b0;
		host_rd      = 1'b0;
		host_addr    = `REG_DIVISOR;
		host_wdata   = 16'd0;
		bit_cycles   = 16 * `UART_RESET_DIVISOR;
		value_errors = 0;
		other_errors = 0;
		cycle_count  = 0;
		// until the data file gives its own
		cycle_limit  = 100000;
		fd = $fopen("tb/uart_console_testdata.txt", "r");
		if (fd == 0) begin
			$display("test data file could not be opened");
			other_errors++;
		end
		// 3 cycles of reset and release on a falling edge
		repeat (3) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;
		compare_value("uart_tx", 16'd1, {15'd0, uart_tx});
		if (fd != 0) begin
			n = $fscanf(fd, " %c", cmd);
			while (n == 1) begin
				execute_command(fd, cmd);
				n = $fscanf(fd, " %c", cmd);
			end
			$fclose(fd);
		end
		// every decoded byte must have been expected
		assert (tx_bytes.size() == 0) else begin
			$display("%0d unexpected bytes decoded on uart_tx", tx_bytes.size());
			other_errors++;
		end
		report_counts();
		if ((value_errors == 0) && (other_errors == 0)) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- tb/uart_console_testdata.txt
# columns: command, then hex arguments: W addr data, R addr expected, S byte, T byte
# D cycles and L cycle limit are decimal; L = 42 commands x 12 bits x 16 x divisor 2 + 2000
L 18128
# reset state, status clear and reset divisor
R 2 0000
R 0 001b
# fast baud for the rest
W 0 0002
R 0 0002
D 40
# host frames in order
W 1 0048
T 48
W 1 0069
T 69
# receive, read clears rx_valid
S 3c
R 2 0002
R 1 003c
R 2 0000
# unread byte then a second one gives overrun
S 11
S 22
R 2 0006
R 2 0002
R 1 0022
R 2 0000
# echo with case swap
W 3 0001
R 3 0001
S 61
T 41
S 5a
T 7a
S 35
T 35
R 2 0006
R 1 0035
R 2 0000
D 40
# host 31 busy, host 2a waits, echo of 71 arrives before the line frees
W 1 0031
W 1 002a
S 71
S 4d
# echo wins the first tie, host the second
T 31
T 51
T 2a
T 6d
R 2 0006
R 1 004d
R 2 0000

//--- uart_console.f
+incdir+common
common/uart_console_pkg.sv
uart/uart_transceiver.sv
design/tx_arbiter.sv
design/echo_responder.sv
design/host_port.sv
design/uart_console.sv
tb/tb_uart_console.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_uart_console
FILELIST  ?= uart_console.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps \
		--top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
